// ==== verilog.f ====
+incdir+rtl
rtl/nx_msg_pkg.sv
rtl/nx_node_pkg.sv
rtl/nx_ram.sv
rtl/nx_node_store.sv
rtl/nx_node_apb.sv
rtl/nx_node_sum.sv
rtl/nx_node_dump.sv
rtl/nx_node_emit.sv
rtl/nx_node.sv
sim/nx_node_asserts.sv
sim/nx_node_tb.sv

// ==== sim/nx_node_tb.sv ====
//////////////////////////////
// Testbench for one compute node
// Loads 64 RAM words over APB, then runs SUM and DUMP commands
// Ranges stay inside written words, the rest of the RAM is never read
// Output back-pressure is random and stalls about a quarter of the cycles
// The first mismatch or stall stops the run
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node_tb;

localparam int APB_TIMEOUT  = 2000;
localparam int IDLE_TIMEOUT = 5000;

logic                      i_clk;
logic                      i_reset;
logic                      i_psel;
logic                      i_penable;
logic                      i_pwrite;
logic [`NX_APB_ADDR_W-1:0] i_paddr;
logic [`NX_RAM_DATA_W-1:0] i_pwdata;
logic                      o_pready;
logic [`NX_RAM_DATA_W-1:0] o_prdata;
logic                      o_pslverr;
nx_msg_pkg::nx_msg_t       o_msg;
logic                      o_msg_valid;
logic                      i_msg_ready;

// Shadow copy of the RAM and the messages still owed per opcode
logic [`NX_RAM_DATA_W-1:0] shadow [0:(2**`NX_RAM_ADDR_W)-1];
nx_msg_pkg::nx_msg_t       sum_exp_q [$];
nx_msg_pkg::nx_msg_t       dump_exp_q [$];
integer                    seed = 32'hc405;
string                     test_name = "reset";
logic                      ready_draw;

nx_node dut_i (
      .i_clk(i_clk), .i_reset(i_reset)
    , .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite)
    , .i_paddr(i_paddr), .i_pwdata(i_pwdata)
    , .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr)
    , .o_msg(o_msg), .o_msg_valid(o_msg_valid), .i_msg_ready(i_msg_ready)
);

always #10 i_clk = ~i_clk;

// Back-pressure is drawn at the falling edge and driven at the rising edge
always @(negedge i_clk) ready_draw = (($random(seed) & 3) != 0);

// Random back-pressure on the output stream
always @(posedge i_clk) begin
    if (i_reset) i_msg_ready <= 1'b0;
    else i_msg_ready <= ready_draw;
end

task automatic halt_on_error();
    $display("Regression failed");
    $fatal(1);
endtask

task automatic stop_with_reason(input string why);
    $display("%s", why);
    halt_on_error();
endtask

task automatic check_msg(input string name, input nx_msg_pkg::nx_msg_t exp,
                         input nx_msg_pkg::nx_msg_t act);
    if (act !== exp) begin
        $display("ERR %s: expected op %0d addr %h data %h, actual op %0d addr %h data %h",
                 name, exp.op, exp.addr, exp.data, act.op, act.addr, act.data);
        halt_on_error();
    end
endtask

task automatic check_word(input string name, input logic [`NX_RAM_DATA_W-1:0] exp,
                          input logic [`NX_RAM_DATA_W-1:0] act);
    if (act !== exp) begin
        $display("ERR %s: expected %h, actual %h", name, exp, act);
        halt_on_error();
    end
endtask

task automatic check_resp(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("ERR %s: expected pslverr %b, actual %b", name, exp, act);
        halt_on_error();
    end
endtask

// Expected SUM result with the total wrapping at 32 bits and the address at the RAM size
function automatic nx_msg_pkg::nx_msg_t ref_sum_msg(input logic [`NX_RAM_ADDR_W-1:0] base,
                                                    input logic [`NX_RAM_ADDR_W-1:0] count_m1);
    nx_msg_pkg::nx_msg_t       m;
    logic [`NX_RAM_ADDR_W-1:0] a;
    int                        i;
    m.op   = nx_msg_pkg::OP_SUM;
    m.addr = base;
    m.data = '0;
    a      = base;
    for (i = 0; i <= count_m1; i++) begin
        m.data = m.data + shadow[a];
        a      = a + 1'b1;
    end
    return m;
endfunction

// Expected DUMP message for one word
function automatic nx_msg_pkg::nx_msg_t ref_dump_msg(input logic [`NX_RAM_ADDR_W-1:0] addr);
    nx_msg_pkg::nx_msg_t m;
    m.op   = nx_msg_pkg::OP_DUMP;
    m.addr = addr;
    m.data = shadow[addr];
    return m;
endfunction

// One APB transfer where waits counts the access cycles with o_pready low
task automatic apb_xfer(input logic is_write, input logic [`NX_APB_ADDR_W-1:0] addr,
                        input logic [`NX_RAM_DATA_W-1:0] wdata,
                        output logic [`NX_RAM_DATA_W-1:0] rdata,
                        output logic err, output int waits);
    @(posedge i_clk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= is_write;
    i_paddr   <= addr;
    i_pwdata  <= wdata;
    @(posedge i_clk);
    i_penable <= 1'b1;
    waits = 0;
    @(posedge i_clk);
    while (!o_pready) begin
        waits++;
        if (waits > APB_TIMEOUT) stop_with_reason("APB transfer stalled, o_pready never rose");
        @(posedge i_clk);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
endtask

task automatic write_word(input logic [`NX_RAM_ADDR_W-1:0] addr,
                          input logic [`NX_RAM_DATA_W-1:0] data);
    logic [`NX_APB_ADDR_W-1:0] byte_addr;
    logic [`NX_RAM_DATA_W-1:0] rdata;
    logic                      err;
    int                        waits;
    byte_addr = '0;
    byte_addr[`NX_RAM_ADDR_W+1:2] = addr;
    apb_xfer(1'b1, byte_addr, data, rdata, err, waits);
    shadow[addr] = data;
    check_resp({test_name, " memory write"}, 1'b0, err);
endtask

// Owed messages are queued before the command can start its engine
task automatic send_cmd(input nx_msg_pkg::nx_op_e op, input logic [`NX_RAM_ADDR_W-1:0] base,
                        input logic [`NX_RAM_ADDR_W-1:0] count_m1, output int waits);
    nx_msg_pkg::nx_cmd_t       cmd;
    logic [`NX_RAM_DATA_W-1:0] rdata;
    logic                      err;
    int                        i;
    cmd          = '0;
    cmd.op       = op;
    cmd.base     = base;
    cmd.count_m1 = count_m1;
    if (op == nx_msg_pkg::OP_SUM) begin
        sum_exp_q.push_back(ref_sum_msg(base, count_m1));
    end else begin
        for (i = 0; i <= count_m1; i++) begin
            dump_exp_q.push_back(ref_dump_msg(base + i[`NX_RAM_ADDR_W-1:0]));
        end
    end
    apb_xfer(1'b1, `NX_CMD_ADDR, cmd, rdata, err, waits);
    check_resp({test_name, " command"}, 1'b0, err);
endtask

task automatic pick_range(output logic [`NX_RAM_ADDR_W-1:0] base,
                          output logic [`NX_RAM_ADDR_W-1:0] count_m1);
    logic [31:0] r;
    r        = $random(seed);
    base     = r[`NX_RAM_ADDR_W-1:0] & 10'h03f;
    r        = $random(seed);
    r        = r % (64 - base);
    count_m1 = r[`NX_RAM_ADDR_W-1:0];
endtask

// All owed messages must arrive before both engines read as idle
task automatic drain_and_check_idle();
    logic [`NX_RAM_DATA_W-1:0] rdata;
    logic                      err;
    int                        waited;
    waited = 0;
    while (sum_exp_q.size() != 0 || dump_exp_q.size() != 0) begin
        @(negedge i_clk);
        waited++;
        if (waited > IDLE_TIMEOUT) stop_with_reason("expected output messages never arrived");
    end
    apb_xfer(1'b0, `NX_CMD_ADDR, '0, rdata, err, waited);
    check_word({test_name, " idle status"}, '0, rdata);
    check_resp({test_name, " status read"}, 1'b0, err);
endtask

// Every accepted message is matched in order against its opcode's queue
always @(posedge i_clk) begin : monitor
    nx_msg_pkg::nx_msg_t want;
    if (!i_reset && o_msg_valid && i_msg_ready) begin
        if (o_msg.op == nx_msg_pkg::OP_SUM && sum_exp_q.size() > 0) begin
            want = sum_exp_q.pop_front();
            check_msg({test_name, " sum message"}, want, o_msg);
        end else if (o_msg.op == nx_msg_pkg::OP_DUMP && dump_exp_q.size() > 0) begin
            want = dump_exp_q.pop_front();
            check_msg({test_name, " dump message"}, want, o_msg);
        end else begin
            stop_with_reason("an output message arrived that no command asked for");
        end
    end
end

// Any failed handshake assertion ends the run at the next edge
always @(posedge i_clk) begin
    if (dut_i.u_asserts.fail_count != 0) stop_with_reason("a handshake assertion failed");
end

initial begin
    nx_msg_pkg::nx_cmd_t       bad;
    logic [`NX_RAM_DATA_W-1:0] rdata;
    logic                      err;
    int                        waits;
    int                        i;
    logic [`NX_RAM_ADDR_W-1:0] base;
    logic [`NX_RAM_ADDR_W-1:0] cnt;
    logic [`NX_RAM_ADDR_W-1:0] base2;
    logic [`NX_RAM_ADDR_W-1:0] cnt2;
    i_clk       = 1'b0;
    i_reset     = 1'b1;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_msg_ready = 1'b0;
    repeat (16) @(posedge i_clk);
    i_reset <= 1'b0;

    // Load the first 64 words and read the status back
    test_name = "load";
    for (i = 0; i < 64; i++) write_word(i[`NX_RAM_ADDR_W-1:0], $random(seed));
    apb_xfer(1'b0, `NX_CMD_ADDR, '0, rdata, err, waits);
    check_word("load status", '0, rdata);
    check_resp("load status read", 1'b0, err);

    // Error responses must not start either engine
    test_name = "errors";
    bad = '0;
    apb_xfer(1'b1, `NX_CMD_ADDR, bad, rdata, err, waits);
    check_resp("op none command", 1'b1, err);
    apb_xfer(1'b1, `NX_CMD_ADDR + 13'h4, '0, rdata, err, waits);
    check_resp("write above command", 1'b1, err);
    apb_xfer(1'b0, 13'h1ffc, '0, rdata, err, waits);
    check_resp("read above command", 1'b1, err);
    drain_and_check_idle();

    test_name = "sum";
    repeat (4) begin
        pick_range(base, cnt);
        send_cmd(nx_msg_pkg::OP_SUM, base, cnt, waits);
        drain_and_check_idle();
    end

    test_name = "dump";
    repeat (3) begin
        pick_range(base, cnt);
        send_cmd(nx_msg_pkg::OP_DUMP, base, cnt, waits);
        drain_and_check_idle();
    end

    // Both engines share the output while each stream keeps its own order
    test_name = "concurrent";
    repeat (3) begin
        pick_range(base, cnt);
        pick_range(base2, cnt2);
        send_cmd(nx_msg_pkg::OP_SUM, base, cnt, waits);
        send_cmd(nx_msg_pkg::OP_DUMP, base2, cnt2, waits);
        drain_and_check_idle();
    end

    // Loads above word 63 steal port A from a SUM over words 0 to 63
    test_name = "stall";
    send_cmd(nx_msg_pkg::OP_SUM, 10'd0, 10'd63, waits);
    for (i = 64; i < 80; i++) write_word(i[`NX_RAM_ADDR_W-1:0], $random(seed));
    drain_and_check_idle();
    send_cmd(nx_msg_pkg::OP_DUMP, 10'd64, 10'd15, waits);
    drain_and_check_idle();

    // A second SUM command must wait for the first result
    test_name = "busy wait";
    send_cmd(nx_msg_pkg::OP_SUM, 10'd0, 10'd47, waits);
    apb_xfer(1'b0, `NX_CMD_ADDR, '0, rdata, err, waits);
    check_word("busy status", 32'h1, rdata);
    pick_range(base, cnt);
    send_cmd(nx_msg_pkg::OP_SUM, base, cnt, waits);
    if (waits == 0) stop_with_reason("second SUM command was not held while SUM was busy");
    drain_and_check_idle();

    // Assertions on the last edge report after it
    @(negedge i_clk);
    if (dut_i.u_asserts.fail_count != 0) begin
        stop_with_reason("a handshake assertion failed");
    end else begin
        $display("Regression passed");
        $finish;
    end
end

endmodule : nx_node_tb

`default_nettype wire

// ==== sim/nx_node_asserts.sv ====
//////////////////////////////
// Handshake checks for one compute node
// Bound to every nx_node instance
// All checks but the reset check are off while reset is high
// Failed checks are counted in fail_count
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nx_node_asserts (
      input  logic                i_clk
    , input  logic                i_reset
    , input  logic                i_psel
    , input  logic                i_penable
    , input  logic                o_pready
    , input  nx_msg_pkg::nx_msg_t o_msg
    , input  logic                o_msg_valid
    , input  logic                i_msg_ready
);

// Number of failed checks over the whole run
int unsigned fail_count = 0;

// A stalled output message must hold until it is taken
a_msg_stable: assert property (
    @(posedge i_clk) disable iff (i_reset)
    (o_msg_valid && !i_msg_ready) |=> (o_msg_valid && $stable(o_msg))
) else begin
    fail_count++;
    $error("o_msg changed or dropped while the stream was stalled");
end

// Ready may only complete an access phase
a_pready_access: assert property (
    @(posedge i_clk) disable iff (i_reset)
    o_pready |-> (i_psel && i_penable)
) else begin
    fail_count++;
    $error("o_pready high outside an APB access phase");
end

// The output stream starts empty
a_reset_valid: assert property (
    @(posedge i_clk) i_reset |=> !o_msg_valid
) else begin
    fail_count++;
    $error("o_msg_valid high right after reset");
end

endmodule : nx_node_asserts

bind nx_node nx_node_asserts u_asserts (
      .i_clk       ( i_clk       )
    , .i_reset     ( i_reset     )
    , .i_psel      ( i_psel      )
    , .i_penable   ( i_penable   )
    , .o_pready    ( o_pready    )
    , .o_msg       ( o_msg       )
    , .o_msg_valid ( o_msg_valid )
    , .i_msg_ready ( i_msg_ready )
);

`default_nettype wire

// ==== rtl/nx_node.sv ====
//////////////////////////////
// One compute node, APB in and message stream out
// SUM and DUMP run side by side on separate RAM ports
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node (
      input  logic                      i_clk
    , input  logic                      i_reset
    // APB slave
    , input  logic                      i_psel
    , input  logic                      i_penable
    , input  logic                      i_pwrite
    , input  logic [`NX_APB_ADDR_W-1:0] i_paddr
    , input  logic [`NX_RAM_DATA_W-1:0] i_pwdata
    , output logic                      o_pready
    , output logic [`NX_RAM_DATA_W-1:0] o_prdata
    , output logic                      o_pslverr
    // Output messages
    , output nx_msg_pkg::nx_msg_t       o_msg
    , output logic                      o_msg_valid
    , input  logic                      i_msg_ready
);

nx_node_pkg::nx_store_wr_t wr;
nx_msg_pkg::nx_cmd_t       cmd;
logic                      sum_start;
logic                      dump_start;
logic                      sum_busy;
logic                      dump_busy;
logic [`NX_RAM_ADDR_W-1:0] a_rd_addr;
logic                      a_rd_en;
logic [`NX_RAM_DATA_W-1:0] a_rd_data;
logic                      a_rd_stall;
logic [`NX_RAM_ADDR_W-1:0] b_rd_addr;
logic                      b_rd_en;
logic [`NX_RAM_DATA_W-1:0] b_rd_data;
nx_msg_pkg::nx_msg_t       sum_msg;
logic                      sum_valid;
logic                      sum_ready;
nx_msg_pkg::nx_msg_t       dump_msg;
logic                      dump_valid;
logic                      dump_ready;

nx_node_apb u_apb (
      .i_clk(i_clk), .i_reset(i_reset)
    , .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite)
    , .i_paddr(i_paddr), .i_pwdata(i_pwdata)
    , .o_pready(o_pready), .o_prdata(o_prdata), .o_pslverr(o_pslverr)
    , .o_wr(wr), .o_sum_start(sum_start), .o_dump_start(dump_start), .o_cmd(cmd)
    , .i_sum_busy(sum_busy), .i_dump_busy(dump_busy)
);

nx_node_store u_store (
      .i_clk(i_clk), .i_reset(i_reset), .i_wr(wr)
    , .i_a_rd_addr(a_rd_addr), .i_a_rd_en(a_rd_en)
    , .o_a_rd_data(a_rd_data), .o_a_rd_stall(a_rd_stall)
    , .i_b_rd_addr(b_rd_addr), .i_b_rd_en(b_rd_en), .o_b_rd_data(b_rd_data)
);

nx_node_sum u_sum (
      .i_clk(i_clk), .i_reset(i_reset)
    , .i_start(sum_start), .i_cmd(cmd), .o_busy(sum_busy)
    , .o_rd_addr(a_rd_addr), .o_rd_en(a_rd_en)
    , .i_rd_data(a_rd_data), .i_rd_stall(a_rd_stall)
    , .o_msg(sum_msg), .o_msg_valid(sum_valid), .i_msg_ready(sum_ready)
);

nx_node_dump u_dump (
      .i_clk(i_clk), .i_reset(i_reset)
    , .i_start(dump_start), .i_cmd(cmd), .o_busy(dump_busy)
    , .o_rd_addr(b_rd_addr), .o_rd_en(b_rd_en), .i_rd_data(b_rd_data)
    , .o_msg(dump_msg), .o_msg_valid(dump_valid), .i_msg_ready(dump_ready)
);

nx_node_emit u_emit (
      .i_clk(i_clk), .i_reset(i_reset)
    , .i_sum_msg(sum_msg), .i_sum_valid(sum_valid), .o_sum_ready(sum_ready)
    , .i_dump_msg(dump_msg), .i_dump_valid(dump_valid), .o_dump_ready(dump_ready)
    , .o_msg(o_msg), .o_msg_valid(o_msg_valid), .i_msg_ready(i_msg_ready)
);

endmodule : nx_node

`default_nettype wire

// ==== rtl/nx_node_emit.sv ====
//////////////////////////////
// Merges the SUM and DUMP messages into one stream
// One output slot, round-robin when both sources are valid
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module nx_node_emit (
      input  logic                i_clk
    , input  logic                i_reset
    // Sources
    , input  nx_msg_pkg::nx_msg_t i_sum_msg
    , input  logic                i_sum_valid
    , output logic                o_sum_ready
    , input  nx_msg_pkg::nx_msg_t i_dump_msg
    , input  logic                i_dump_valid
    , output logic                o_dump_ready
    // Merged output
    , output nx_msg_pkg::nx_msg_t o_msg
    , output logic                o_msg_valid
    , input  logic                i_msg_ready
);

logic can_take;
logic pick_dump;
logic last_dump_q;

// The slot takes a new message when empty or when it drains this cycle
assign can_take  = !o_msg_valid || i_msg_ready;
// DUMP wins alone, or on a tie when SUM was served last
assign pick_dump = i_dump_valid && (!i_sum_valid || !last_dump_q);

assign o_sum_ready  = can_take && i_sum_valid && !pick_dump;
assign o_dump_ready = can_take && pick_dump;

always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_msg_valid <= 1'b0;
        last_dump_q <= 1'b0;
    end else if (o_sum_ready || o_dump_ready) begin
        o_msg_valid <= 1'b1;
        last_dump_q <= pick_dump;
    end else if (i_msg_ready) begin
        o_msg_valid <= 1'b0;
    end
end

// Payload of the slot
always_ff @(posedge i_clk) begin
    if (o_sum_ready || o_dump_ready) o_msg <= pick_dump ? i_dump_msg : i_sum_msg;
end

endmodule : nx_node_emit

`default_nettype wire

// ==== rtl/nx_node_dump.sv ====
//////////////////////////////
// DUMP engine on store port B
// Emits one message per word from base, in address order
// The next word is read only after the current one is accepted
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node_dump (
      input  logic                      i_clk
    , input  logic                      i_reset
    // Command
    , input  logic                      i_start
    , input  nx_msg_pkg::nx_cmd_t       i_cmd
    , output logic                      o_busy
    // Store port B
    , output logic [`NX_RAM_ADDR_W-1:0] o_rd_addr
    , output logic                      o_rd_en
    , input  logic [`NX_RAM_DATA_W-1:0] i_rd_data
    // Word messages
    , output nx_msg_pkg::nx_msg_t       o_msg
    , output logic                      o_msg_valid
    , input  logic                      i_msg_ready
);

nx_node_pkg::nx_eng_state_e state_q;
logic [`NX_RAM_ADDR_W-1:0]  addr_q;
logic [`NX_RAM_ADDR_W-1:0]  left_q;
logic [`NX_RAM_DATA_W-1:0]  data_q;

// Read, capture and offer each word in turn
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        state_q <= nx_node_pkg::ST_IDLE;
    end else begin
        case (state_q)
            nx_node_pkg::ST_IDLE: if (i_start) state_q <= nx_node_pkg::ST_READ;
            nx_node_pkg::ST_READ: state_q <= nx_node_pkg::ST_WAIT;
            nx_node_pkg::ST_WAIT: state_q <= nx_node_pkg::ST_EMIT;
            nx_node_pkg::ST_EMIT: begin
                // Busy ends only with the acceptance of the last word
                if (i_msg_ready) begin
                    state_q <= (left_q == '0) ? nx_node_pkg::ST_IDLE : nx_node_pkg::ST_READ;
                end
            end
            default: state_q <= nx_node_pkg::ST_IDLE;
        endcase
    end
end

// Address steps after acceptance so the message stays stable while offered
always_ff @(posedge i_clk) begin
    if (i_start) begin
        addr_q <= i_cmd.base;
        left_q <= i_cmd.count_m1;
    end else if (state_q == nx_node_pkg::ST_EMIT && i_msg_ready) begin
        addr_q <= addr_q + 1'b1;
        left_q <= left_q - 1'b1;
    end
    if (state_q == nx_node_pkg::ST_WAIT) data_q <= i_rd_data;
end

assign o_busy      = state_q != nx_node_pkg::ST_IDLE;
assign o_rd_en     = state_q == nx_node_pkg::ST_READ;
assign o_rd_addr   = addr_q;
assign o_msg_valid = state_q == nx_node_pkg::ST_EMIT;
assign o_msg.op    = nx_msg_pkg::OP_DUMP;
assign o_msg.addr  = addr_q;
assign o_msg.data  = data_q;

endmodule : nx_node_dump

`default_nettype wire

// ==== rtl/nx_node_sum.sv ====
//////////////////////////////
// SUM engine on store port A
// Adds count_m1+1 words from base, modulo 2^32
// Each word takes two cycles plus any stalled cycles
// Busy stays high until the result message is accepted
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node_sum (
      input  logic                      i_clk
    , input  logic                      i_reset
    // Command
    , input  logic                      i_start
    , input  nx_msg_pkg::nx_cmd_t       i_cmd
    , output logic                      o_busy
    // Store port A
    , output logic [`NX_RAM_ADDR_W-1:0] o_rd_addr
    , output logic                      o_rd_en
    , input  logic [`NX_RAM_DATA_W-1:0] i_rd_data
    , input  logic                      i_rd_stall
    // Result message
    , output nx_msg_pkg::nx_msg_t       o_msg
    , output logic                      o_msg_valid
    , input  logic                      i_msg_ready
);

nx_node_pkg::nx_eng_state_e state_q;
logic [`NX_RAM_ADDR_W-1:0]  base_q;
logic [`NX_RAM_ADDR_W-1:0]  addr_q;
logic [`NX_RAM_ADDR_W-1:0]  left_q;
logic [`NX_RAM_DATA_W-1:0]  total_q;

// Sequence one read per word, retrying any read that lost port A
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        state_q <= nx_node_pkg::ST_IDLE;
    end else begin
        case (state_q)
            nx_node_pkg::ST_IDLE: if (i_start) state_q <= nx_node_pkg::ST_READ;
            nx_node_pkg::ST_READ: if (!i_rd_stall) state_q <= nx_node_pkg::ST_WAIT;
            nx_node_pkg::ST_WAIT: begin
                // The last word of the range has no words left behind it
                state_q <= (left_q == '0) ? nx_node_pkg::ST_EMIT : nx_node_pkg::ST_READ;
            end
            nx_node_pkg::ST_EMIT: if (i_msg_ready) state_q <= nx_node_pkg::ST_IDLE;
            default: state_q <= nx_node_pkg::ST_IDLE;
        endcase
    end
end

// Range walk and running total, data is valid in ST_WAIT
always_ff @(posedge i_clk) begin
    if (i_start) begin
        base_q  <= i_cmd.base;
        addr_q  <= i_cmd.base;
        left_q  <= i_cmd.count_m1;
        total_q <= '0;
    end else if (state_q == nx_node_pkg::ST_WAIT) begin
        addr_q  <= addr_q + 1'b1;
        left_q  <= left_q - 1'b1;
        total_q <= total_q + i_rd_data;
    end
end

assign o_busy      = state_q != nx_node_pkg::ST_IDLE;
assign o_rd_en     = state_q == nx_node_pkg::ST_READ;
assign o_rd_addr   = addr_q;
assign o_msg_valid = state_q == nx_node_pkg::ST_EMIT;
assign o_msg.op    = nx_msg_pkg::OP_SUM;
assign o_msg.addr  = base_q;
assign o_msg.data  = total_q;

endmodule : nx_node_sum

`default_nettype wire

// ==== rtl/nx_node_apb.sv ====
//////////////////////////////
// APB slave for memory loads and commands
// RAM words live below NX_CMD_ADDR, word index is the byte address over four
// A command to a busy engine waits, OP_NONE or a high address errors
// Every read returns the engine status word only
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node_apb (
      input  logic                      i_clk
    , input  logic                      i_reset
    // APB slave
    , input  logic                      i_psel
    , input  logic                      i_penable
    , input  logic                      i_pwrite
    , input  logic [`NX_APB_ADDR_W-1:0] i_paddr
    , input  logic [`NX_RAM_DATA_W-1:0] i_pwdata
    , output logic                      o_pready
    , output logic [`NX_RAM_DATA_W-1:0] o_prdata
    , output logic                      o_pslverr
    // Towards the store and the engines
    , output nx_node_pkg::nx_store_wr_t o_wr
    , output logic                      o_sum_start
    , output logic                      o_dump_start
    , output nx_msg_pkg::nx_cmd_t       o_cmd
    , input  logic                      i_sum_busy
    , input  logic                      i_dump_busy
);

logic is_mem;
logic is_cmd;
logic blocked;
logic error;
logic pending;
logic done;

// Address decode
assign is_mem = i_paddr < `NX_CMD_ADDR;
assign is_cmd = i_paddr == `NX_CMD_ADDR;
assign o_cmd  = nx_msg_pkg::nx_cmd_t'(i_pwdata);

// A command for an engine still running must wait for it
assign blocked = i_pwrite && is_cmd &&
                 ((o_cmd.op == nx_msg_pkg::OP_SUM  && i_sum_busy) ||
                  (o_cmd.op == nx_msg_pkg::OP_DUMP && i_dump_busy));
assign error   = (i_paddr > `NX_CMD_ADDR) ||
                 (i_pwrite && is_cmd && o_cmd.op != nx_msg_pkg::OP_SUM &&
                  o_cmd.op != nx_msg_pkg::OP_DUMP);

// A transfer is pending from its setup phase until the completing access cycle
assign pending = i_psel && !(i_penable && o_pready);
assign done    = i_psel && i_penable && o_pready;

// Ready is registered during setup, which gives zero wait states when not blocked
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_pready  <= 1'b0;
        o_pslverr <= 1'b0;
    end else begin
        o_pready  <= pending && !blocked;
        o_pslverr <= pending && !blocked && error;
    end
end

// Writes and starts last exactly the completing cycle of the transfer
assign o_wr.en      = done && i_pwrite && is_mem;
assign o_wr.addr    = i_paddr[`NX_RAM_ADDR_W+1:2];
assign o_wr.data    = i_pwdata;
assign o_sum_start  = done && i_pwrite && is_cmd && o_cmd.op == nx_msg_pkg::OP_SUM;
assign o_dump_start = done && i_pwrite && is_cmd && o_cmd.op == nx_msg_pkg::OP_DUMP;

// Status word with one busy bit per engine
assign o_prdata = {{(`NX_RAM_DATA_W-2){1'b0}}, i_dump_busy, i_sum_busy};

endmodule : nx_node_apb

`default_nettype wire

// ==== rtl/nx_node_store.sv ====
//////////////////////////////
// Node memory with one write stream and two read ports
// Writes take priority on RAM port A and stall the port A reader
// A stalled read is dropped and must be issued again
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_node_store (
      input  logic                      i_clk
    , input  logic                      i_reset
    // Load path from the APB slave
    , input  nx_node_pkg::nx_store_wr_t i_wr
    // Read port A, shared with the load path
    , input  logic [`NX_RAM_ADDR_W-1:0] i_a_rd_addr
    , input  logic                      i_a_rd_en
    , output logic [`NX_RAM_DATA_W-1:0] o_a_rd_data
    , output logic                      o_a_rd_stall
    // Read port B, private to DUMP
    , input  logic [`NX_RAM_ADDR_W-1:0] i_b_rd_addr
    , input  logic                      i_b_rd_en
    , output logic [`NX_RAM_DATA_W-1:0] o_b_rd_data
);

logic [`NX_RAM_ADDR_W-1:0] a_addr;
logic                      a_en;

// A pending write owns port A for this cycle
assign a_addr       = i_wr.en ? i_wr.addr : i_a_rd_addr;
assign a_en         = i_wr.en || i_a_rd_en;
// The reader learns in the same cycle that its request was not served
assign o_a_rd_stall = i_wr.en;

nx_ram u_ram (
      .i_clk       ( i_clk        )
    , .i_reset     ( i_reset      )
    , .i_a_addr    ( a_addr       )
    , .i_a_wr_data ( i_wr.data    )
    , .i_a_wr_en   ( i_wr.en      )
    , .i_a_en      ( a_en         )
    , .o_a_rd_data ( o_a_rd_data  )
    , .i_b_addr    ( i_b_rd_addr  )
    , .i_b_en      ( i_b_rd_en    )
    , .o_b_rd_data ( o_b_rd_data  )
);

endmodule : nx_node_store

`default_nettype wire

// ==== rtl/nx_ram.sv ====
//////////////////////////////
// Dual-port RAM, port A reads and writes, port B only reads
// Read data follows an enable by one cycle and holds otherwise
// A port A write returns the old word on o_a_rd_data
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "nx_node_cfg.svh"

module nx_ram (
      input  logic                      i_clk
    , input  logic                      i_reset
    // Port A
    , input  logic [`NX_RAM_ADDR_W-1:0] i_a_addr
    , input  logic [`NX_RAM_DATA_W-1:0] i_a_wr_data
    , input  logic                      i_a_wr_en
    , input  logic                      i_a_en
    , output logic [`NX_RAM_DATA_W-1:0] o_a_rd_data
    // Port B
    , input  logic [`NX_RAM_ADDR_W-1:0] i_b_addr
    , input  logic                      i_b_en
    , output logic [`NX_RAM_DATA_W-1:0] o_b_rd_data
);

// Storage array covering the whole word address space
logic [`NX_RAM_DATA_W-1:0] mem [0:(2**`NX_RAM_ADDR_W)-1];

// Only port A can update the array
always_ff @(posedge i_clk) begin
    if (i_a_en && i_a_wr_en) mem[i_a_addr] <= i_a_wr_data;
end

// Registered read outputs, each updates only when its port is enabled
always_ff @(posedge i_clk) begin
    if (i_reset) begin
        o_a_rd_data <= '0;
        o_b_rd_data <= '0;
    end else begin
        if (i_a_en) o_a_rd_data <= mem[i_a_addr];
        if (i_b_en) o_b_rd_data <= mem[i_b_addr];
    end
end

endmodule : nx_ram

`default_nettype wire

// ==== rtl/nx_node_pkg.sv ====
//////////////////////////////
// Formats used only inside the node
// Both engines step through the same state encoding
//////////////////////////////
`default_nettype none

`include "nx_node_cfg.svh"

package nx_node_pkg;

    // A single word write into the store, valid while en is high
    typedef struct packed {
        logic                      en;
        logic [`NX_RAM_ADDR_W-1:0] addr;
        logic [`NX_RAM_DATA_W-1:0] data;
    } nx_store_wr_t;

    // Engine states, a word is read in ST_READ and returned in ST_WAIT
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_READ = 2'd1,
        ST_WAIT = 2'd2,
        ST_EMIT = 2'd3
    } nx_eng_state_e;

endpackage

`default_nettype wire

// ==== rtl/nx_msg_pkg.sv ====
//////////////////////////////
// Formats seen outside the node
// The command word must pack into one APB data word
// The opcode is shared by commands and output messages
//////////////////////////////
`default_nettype none

`include "nx_node_cfg.svh"

package nx_msg_pkg;

    // Operation carried by a command and echoed in every output message
    typedef enum logic [1:0] {
        OP_NONE = 2'd0,
        OP_SUM  = 2'd1,
        OP_DUMP = 2'd2
    } nx_op_e;

    // Command register layout with the opcode in the lowest bits
    typedef struct packed {
        logic [`NX_RAM_DATA_W-2-2*`NX_RAM_ADDR_W-1:0] spare;
        logic [`NX_RAM_ADDR_W-1:0]                    count_m1;
        logic [`NX_RAM_ADDR_W-1:0]                    base;
        nx_op_e                                       op;
    } nx_cmd_t;

    // One output message, for SUM the address is the base of the range
    typedef struct packed {
        nx_op_e                    op;
        logic [`NX_RAM_ADDR_W-1:0] addr;
        logic [`NX_RAM_DATA_W-1:0] data;
    } nx_msg_t;

endpackage

`default_nettype wire

// ==== rtl/nx_node_cfg.svh ====
//////////////////////////////
// Sizing for one node of the compute fabric
// RAM word address and data widths set the store depth and word size
// The APB space maps RAM words below NX_CMD_ADDR and the command register at it
// Status reads and all error responses depend on NX_CMD_ADDR
//////////////////////////////
`ifndef NX_NODE_CFG_SVH
`define NX_NODE_CFG_SVH

// Word address width of the store, 1024 words
`define NX_RAM_ADDR_W 10
// Word width of the store, also the APB data width
`define NX_RAM_DATA_W 32
// APB byte address width
`define NX_APB_ADDR_W 13
// Byte address of the command register
`define NX_CMD_ADDR 13'h1000

`endif
